//--- verilog/flash_dump_pkg.sv
// ----------------------------------------------------------------------
// constants and bus structs shared by the flash dump blocks
// BIT_CYCLES truncates, so the baud rate is about 0.2 % fast
// ----------------------------------------------------------------------

`default_nettype none

package flash_dump_pkg;

	// clocks
	localparam int CLK_HZ     = 27_000_000;
	localparam int BAUD       = 115_200;
	localparam int BIT_CYCLES = CLK_HZ / BAUD;

	// sizes
	localparam int WORD_BITS  = 8;
	localparam int ADDR_WORDS = 3;
	localparam int ADDR_BITS  = ADDR_WORDS * WORD_BITS;

	// flash read opcode, no dummy cycles
	localparam logic [WORD_BITS - 1:0] READ_CMD = 8'h03;

	// console
	localparam int GAP_CYCLES = 1000;
	localparam int LINE_CHARS = 45;

	typedef struct packed {
		logic [ADDR_BITS - 1:0] addr;
	} flash_req_t;

	// one console line worth of payload
	typedef struct packed {
		logic [ADDR_BITS - 1:0] addr;
		logic [WORD_BITS - 1:0] data;
	} dump_item_t;

	typedef struct packed {
		logic sclk;
		logic cs_n;
		logic mosi;
	} spi_out_t;

endpackage

`default_nettype wire

//--- verilog/spi_flash_reader.sv
// ----------------------------------------------------------------------
// SPI mode 0 single-byte read, sclk at half of clk27
// miso must be valid at the rising sclk, rd_data holds while rd_ack high
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader (
	input wire clk27,
	input wire rst,

	// request channel
	input wire rd_req,
	input wire flash_dump_pkg::flash_req_t rd_addr,
	output logic rd_ack,
	output logic [flash_dump_pkg::WORD_BITS - 1:0] rd_data,

	// flash pins
	output flash_dump_pkg::spi_out_t spi,
	input wire miso
);

	typedef enum logic [1:0] {
		r_idle,
		r_shift,
		r_latch,
		r_ack
	} rd_state_t;

	rd_state_t state;

	// command, address and the read byte share one shift register
	logic [(flash_dump_pkg::ADDR_WORDS + 2) * flash_dump_pkg::WORD_BITS - 1:0] shreg;
	logic [5:0] bit_cnt;

	// ------------------------------------------------------------------
	// control and pins
	// ------------------------------------------------------------------
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			state <= r_idle;
			bit_cnt <= '0;
			rd_ack <= 1'b0;
			spi.sclk <= 1'b0;
			spi.cs_n <= 1'b1;
			spi.mosi <= 1'b0;
		end else begin
			case (state)
				r_idle: begin
					if (rd_req) begin
						spi.cs_n <= 1'b0;
						// first opcode bit set up before the first rising sclk
						spi.mosi <= flash_dump_pkg::READ_CMD[flash_dump_pkg::WORD_BITS - 1];
						bit_cnt <= '0;
						state <= r_shift;
					end
				end

				r_shift: begin
					if (!spi.sclk) begin
						spi.sclk <= 1'b1;
					end else begin
						// falling edge, next bit was shifted up at the rising edge
						spi.sclk <= 1'b0;
						spi.mosi <= shreg[$high(shreg)];
						if (bit_cnt == 6'($bits(shreg) - 1)) begin
							spi.cs_n <= 1'b1;
							state <= r_latch;
						end else begin
							bit_cnt <= bit_cnt + 6'd1;
						end
					end
				end

				r_latch: begin
					rd_ack <= 1'b1;
					state <= r_ack;
				end

				r_ack: begin
					if (!rd_req) begin
						rd_ack <= 1'b0;
						state <= r_idle;
					end
				end

				default: state <= r_idle;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// data path
	// ------------------------------------------------------------------
	always_ff @(posedge clk27) begin
		if (state == r_idle && rd_req) begin
			shreg <= {flash_dump_pkg::READ_CMD, rd_addr.addr,
				{flash_dump_pkg::WORD_BITS{1'b0}}};
		end else if (state == r_shift && !spi.sclk) begin
			// sample miso as sclk rises
			shreg <= {shreg[$high(shreg) - 1:0], miso};
		end

		if (state == r_latch)
			rd_data <= shreg[flash_dump_pkg::WORD_BITS - 1:0];
	end

	// no clock pulses may reach a deselected flash
	sclk_idle_when_deselected: assert property (
		@(posedge clk27) disable iff (rst)
		spi.cs_n |-> !spi.sclk
	);

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
// ----------------------------------------------------------------------
// 8N1 transmitter, LSB first, one character per req/ack transaction
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input wire clk27,
	input wire rst,

	input wire char_req,
	input wire [flash_dump_pkg::WORD_BITS - 1:0] char,
	output logic char_ack,

	output logic serial_tx
);

	typedef enum logic [1:0] {
		tx_idle,
		tx_send,
		tx_ack
	} tx_state_t;

	tx_state_t state;

	logic [$clog2(flash_dump_pkg::BIT_CYCLES) - 1:0] baud_cnt;
	logic [3:0] bit_cnt;

	// stop bit, data, start bit; all ones when idle
	logic [flash_dump_pkg::WORD_BITS + 1:0] frame;

	assign serial_tx = frame[0];

	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			state <= tx_idle;
			baud_cnt <= '0;
			bit_cnt <= '0;
			frame <= '1;
			char_ack <= 1'b0;
		end else begin
			case (state)
				tx_idle: begin
					if (char_req) begin
						frame <= {1'b1, char, 1'b0};
						baud_cnt <= '0;
						bit_cnt <= '0;
						state <= tx_send;
					end
				end

				tx_send: begin
					if (baud_cnt == $bits(baud_cnt)'(flash_dump_pkg::BIT_CYCLES - 1)) begin
						baud_cnt <= '0;
						frame <= {1'b1, frame[$high(frame):1]};
						// ack once the stop bit has run its full length
						if (bit_cnt == 4'(flash_dump_pkg::WORD_BITS + 1)) begin
							char_ack <= 1'b1;
							state <= tx_ack;
						end else begin
							bit_cnt <= bit_cnt + 4'd1;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end

				tx_ack: begin
					if (!char_req) begin
						char_ack <= 1'b0;
						state <= tx_idle;
					end
				end

				default: state <= tx_idle;
			endcase
		end
	end

	// requester keeps the character steady until the frame is done
	char_stable_during_req: assert property (
		@(posedge clk27) disable iff (rst)
		(char_req && !char_ack) |=> (!char_req || char_ack || $stable(char))
	);

endmodule

`default_nettype wire

//--- verilog/line_formatter.sv
// ----------------------------------------------------------------------
// prints one address/data item as a 45 character line
// line_item must stay stable while line_req is high
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module line_formatter (
	input wire clk27,
	input wire rst,

	// item from the sequencer
	input wire line_req,
	input wire flash_dump_pkg::dump_item_t line_item,
	output logic line_ack,

	// characters to the transmitter
	output logic char_req,
	output logic [flash_dump_pkg::WORD_BITS - 1:0] char,
	input wire char_ack
);

	typedef enum logic [3:0] {
		f_idle,
		f_addr,
		f_addr_sep,
		f_colon,
		f_raw,
		f_space,
		f_bin,
		f_hex_pfx,
		f_hex,
		f_eol,
		f_done
	} field_t;

	field_t field;
	field_t next_field;

	// character index inside the current field
	logic [4:0] pos;
	logic last_pos;
	logic [3:0] nibble;

	// ------------------------------------------------------------------
	// field sequencing
	// ------------------------------------------------------------------
	always_comb begin
		case (field)
			f_addr: last_pos = (pos == 5'(flash_dump_pkg::ADDR_BITS - 1));
			f_colon, f_hex, f_eol: last_pos = (pos == 5'd1);
			f_bin: last_pos = (pos == 5'(flash_dump_pkg::WORD_BITS - 1));
			f_hex_pfx: last_pos = (pos == 5'd2);
			default: last_pos = 1'b1;
		endcase

		case (field)
			f_addr: next_field = f_colon;
			f_colon: next_field = f_raw;
			f_raw: next_field = f_space;
			f_space: next_field = f_bin;
			f_bin: next_field = f_hex_pfx;
			f_hex_pfx: next_field = f_hex;
			f_hex: next_field = f_eol;
			default: next_field = f_done;
		endcase
	end

	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			field <= f_idle;
			pos <= '0;
			char_req <= 1'b0;
			line_ack <= 1'b0;
		end else begin
			case (field)
				f_idle: begin
					if (line_req) begin
						field <= f_addr;
						pos <= '0;
						char_req <= 1'b1;
					end
				end

				f_done: begin
					if (!line_req) begin
						line_ack <= 1'b0;
						field <= f_idle;
					end
				end

				default: begin
					if (char_req) begin
						if (char_ack)
							char_req <= 1'b0;
					end else if (!char_ack) begin
						// previous character fully acknowledged
						if (field == f_addr_sep) begin
							field <= f_addr;
							char_req <= 1'b1;
						end else if (!last_pos) begin
							pos <= pos + 5'd1;
							char_req <= 1'b1;
							// "_" after each of the first two address bytes
							if (field == f_addr && pos[2:0] == 3'd7)
								field <= f_addr_sep;
						end else begin
							field <= next_field;
							pos <= '0;
							if (field == f_eol)
								line_ack <= 1'b1;
							else
								char_req <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// character select
	// ------------------------------------------------------------------
	always_comb begin
		nibble = (pos == 5'd0) ? line_item.data[7:4] : line_item.data[3:0];

		case (field)
			f_addr: char = line_item.addr[flash_dump_pkg::ADDR_BITS - 1 - pos] ? "1" : "0";
			f_addr_sep: char = "_";
			f_colon: char = (pos == 5'd0) ? ":" : " ";
			f_raw: char = line_item.data;
			f_space: char = " ";
			f_bin: char = line_item.data[flash_dump_pkg::WORD_BITS - 1 - pos] ? "1" : "0";
			f_hex_pfx: char = (pos == 5'd0) ? " " : (pos == 5'd1) ? "0" : "x";
			// upper-case hex digit
			f_hex: char = (nibble < 4'd10) ? 8'h30 + 8'(nibble) : 8'h37 + 8'(nibble);
			f_eol: char = (pos == 5'd0) ? 8'h0d : 8'h0a;
			default: char = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/dump_sequencer.sv
// ----------------------------------------------------------------------
// gap, flash read, line print, next address; address wraps at 24 bits
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module dump_sequencer (
	input wire clk27,
	input wire rst,

	// flash read channel
	output logic rd_req,
	output flash_dump_pkg::flash_req_t rd_addr,
	input wire rd_ack,
	input wire [flash_dump_pkg::WORD_BITS - 1:0] rd_data,

	// line print channel
	output logic line_req,
	output flash_dump_pkg::dump_item_t line_item,
	input wire line_ack
);

	typedef enum logic [2:0] {
		s_gap,
		s_read,
		s_read_end,
		s_line,
		s_line_end
	} seq_state_t;

	seq_state_t state;
	logic [$clog2(flash_dump_pkg::GAP_CYCLES) - 1:0] gap_cnt;

	// rd_addr doubles as the address counter
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			state <= s_gap;
			gap_cnt <= '0;
			rd_req <= 1'b0;
			line_req <= 1'b0;
			rd_addr <= '0;
		end else begin
			case (state)
				s_gap: begin
					if (gap_cnt == $bits(gap_cnt)'(flash_dump_pkg::GAP_CYCLES - 1)) begin
						gap_cnt <= '0;
						rd_req <= 1'b1;
						state <= s_read;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				s_read: begin
					if (rd_ack) begin
						rd_req <= 1'b0;
						state <= s_read_end;
					end
				end
				s_read_end: begin
					if (!rd_ack) begin
						line_req <= 1'b1;
						state <= s_line;
					end
				end
				s_line: begin
					if (line_ack) begin
						line_req <= 1'b0;
						state <= s_line_end;
					end
				end
				s_line_end: begin
					if (!line_ack) begin
						rd_addr.addr <= rd_addr.addr + 1'b1;
						state <= s_gap;
					end
				end
				default: state <= s_gap;
			endcase
		end
	end

	// byte and address captured together while rd_data is valid
	always_ff @(posedge clk27) begin
		if (state == s_read && rd_ack) begin
			line_item.addr <= rd_addr.addr;
			line_item.data <= rd_data;
		end
	end

	// reads and prints never overlap
	one_channel_active: assert property (
		@(posedge clk27) disable iff (rst)
		!(rd_req && line_req)
	);

endmodule

`default_nettype wire

//--- verilog/flash_dump_top.sv
// ----------------------------------------------------------------------
// flash to console dump, 115200 8N1 from a 27 MHz clock
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module flash_dump_top (
	input wire clk27,
	input wire rst,

	// flash pins
	output wire flash_dump_pkg::spi_out_t spi,
	input wire miso,

	// console
	output wire serial_tx
);

	// ------------------------------------------------------------------
	// channels
	// ------------------------------------------------------------------
	wire rd_req;
	wire rd_ack;
	wire flash_dump_pkg::flash_req_t rd_addr;
	wire [flash_dump_pkg::WORD_BITS - 1:0] rd_data;

	wire line_req;
	wire line_ack;
	wire flash_dump_pkg::dump_item_t line_item;

	wire char_req;
	wire char_ack;
	wire [flash_dump_pkg::WORD_BITS - 1:0] tx_char;

	// ------------------------------------------------------------------
	// blocks
	// ------------------------------------------------------------------
	dump_sequencer u_sequencer (
		.clk27(clk27), .rst(rst),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_ack(rd_ack), .rd_data(rd_data),
		.line_req(line_req), .line_item(line_item), .line_ack(line_ack)
	);

	spi_flash_reader u_reader (
		.clk27(clk27), .rst(rst),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_ack(rd_ack), .rd_data(rd_data),
		.spi(spi), .miso(miso)
	);

	line_formatter u_formatter (
		.clk27(clk27), .rst(rst),
		.line_req(line_req), .line_item(line_item), .line_ack(line_ack),
		.char_req(char_req), .char(tx_char), .char_ack(char_ack)
	);

	uart_tx u_uart (
		.clk27(clk27), .rst(rst),
		.char_req(char_req), .char(tx_char), .char_ack(char_ack),
		.serial_tx(serial_tx)
	);

endmodule

`default_nettype wire

//--- verification/flash_model.sv
// ----------------------------------------------------------------------
// SPI mode 0 flash, read opcode 0x03 only, byte = addr[7:0] ^ 8'hA5
// other opcodes read back 8'h00; erase and write are not modeled
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module flash_model (
	input wire flash_dump_pkg::spi_out_t spi,
	output logic miso,

	// last command and address seen, for the testbench
	output logic [7:0] last_cmd,
	output logic [23:0] last_addr
);

	wire sclk;
	wire cs_n;
	wire mosi;

	assign sclk = spi.sclk;
	assign cs_n = spi.cs_n;
	assign mosi = spi.mosi;

	// opcode and address as shifted in
	logic [31:0] rx;
	logic [7:0] data;
	int bit_cnt;

	initial begin
		miso = 1'b0;
		last_cmd = 8'h00;
		last_addr = 24'h000000;
		rx = 32'h0;
		data = 8'h00;
		bit_cnt = 0;
	end

	always @(negedge cs_n) begin
		bit_cnt = 0;
		rx = 32'h0;
	end

	always @(posedge cs_n)
		miso <= 1'b0;

	// mosi sampled on the rising sclk
	always @(posedge sclk) begin
		if (!cs_n) begin
			if (bit_cnt < 32)
				rx = {rx[30:0], mosi};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 32) begin
				last_cmd = rx[31:24];
				last_addr = rx[23:0];
				data = (rx[31:24] == 8'h03) ? (rx[7:0] ^ 8'hA5) : 8'h00;
			end
		end
	end

	// data shifted out MSB first on the falling sclk
	always @(negedge sclk) begin
		if (!cs_n && bit_cnt >= 32 && bit_cnt < 40)
			miso <= data[39 - bit_cnt];
	end

endmodule

`default_nettype wire

//--- verification/tb_flash_dump.sv
// ----------------------------------------------------------------------
// directed tests of the flash dump console output at 20 ns per clock
// the flash model fixes the byte at address a to a[7:0] ^ 8'hA5
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_flash_dump;

	logic clk27;
	logic rst;
	wire miso;
	wire serial_tx;
	wire flash_dump_pkg::spi_out_t spi;
	wire [7:0] last_cmd;
	wire [23:0] last_addr;

	integer seed;
	int test_count;
	int check_count;
	int error_count;

	// one received console line with start bit low run and stop bit per char
	logic [7:0] line_buf [flash_dump_pkg::LINE_CHARS];
	int start_len [flash_dump_pkg::LINE_CHARS];
	logic stop_bit [flash_dump_pkg::LINE_CHARS];

	// start bit runs and stop bits of the first line for the frame timing test
	int first_start_len [flash_dump_pkg::LINE_CHARS];
	logic first_stop [flash_dump_pkg::LINE_CHARS];

	flash_dump_top UUT (
		.clk27(clk27),
		.rst(rst),
		.spi(spi),
		.miso(miso),
		.serial_tx(serial_tx)
	);

	flash_model u_flash (
		.spi(spi),
		.miso(miso),
		.last_cmd(last_cmd),
		.last_addr(last_addr)
	);

	initial begin
		clk27 = 1'b0;
		forever #10 clk27 = ~clk27;
	end

	// ------------------------------------------------------------------
	// checking and reporting
	// ------------------------------------------------------------------
	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, error_count - errors_before);
	endtask

	task automatic abort_run(input string reason);
		$display("timeout: %s", reason);
		$display("tests run %0d, checks %0d, errors %0d", test_count, check_count,
			error_count + 1);
		$display(">>> FAIL");
		$finish;
	endtask

	// ------------------------------------------------------------------
	// expected line contents
	// ------------------------------------------------------------------
	function automatic logic [7:0] model_byte(input logic [23:0] addr);
		return addr[7:0] ^ 8'hA5;
	endfunction

	function automatic string hex_text(input logic [3:0] nib);
		string digits;
		digits = "0123456789ABCDEF";
		return digits.substr(nib, nib);
	endfunction

	function automatic logic [7:0] expected_char(input logic [23:0] addr, input int idx);
		string text;
		logic [7:0] data;
		data = model_byte(addr);
		// "?" holds the place of the raw byte at index 28
		text = {$sformatf("%b_%b_%b: ", addr[23:16], addr[15:8], addr[7:0]), "?",
			$sformatf(" %b 0x", data), hex_text(data[7:4]), hex_text(data[3:0]),
			"\015\012"};
		if (idx == 28)
			return data;
		else
			return text[idx];
	endfunction

	// eight "0"/"1" characters of line_buf, MSB first
	function automatic logic [7:0] bin_field(input int first);
		logic [7:0] v;
		v = 8'h00;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], line_buf[first + i] == "1"};
		return v;
	endfunction

	function automatic logic [3:0] hex_value(input logic [7:0] c);
		if (c >= "A")
			return 4'(c - "A" + 8'd10);
		else
			return 4'(c - "0");
	endfunction

	// start bit plus trailing zero data bits in bit times
	function automatic int low_bits(input logic [7:0] c);
		int n;
		n = 0;
		while (n < 8 && !c[n])
			n++;
		return n + 1;
	endfunction

	// ------------------------------------------------------------------
	// UART capture on the falling clock
	// ------------------------------------------------------------------
	task automatic receive_char(output logic [7:0] c, output int low_run, output logic stop);
		int waited;
		int limit;
		int mid;
		bit in_run;
		limit = 2 * flash_dump_pkg::GAP_CYCLES + 20 * flash_dump_pkg::BIT_CYCLES;
		mid = flash_dump_pkg::BIT_CYCLES / 2;
		c = 8'h00;
		low_run = 0;
		stop = 1'b0;
		waited = 0;
		do begin
			@(negedge clk27);
			waited++;
		end while (serial_tx !== 1'b0 && waited < limit);

		if (serial_tx !== 1'b0) begin
			abort_run("no start bit seen on serial_tx");
		end else begin
			low_run = 1;
			in_run = 1'b1;
			for (int n = 1; n <= 9 * flash_dump_pkg::BIT_CYCLES + mid; n++) begin
				@(negedge clk27);
				if (in_run && serial_tx === 1'b0)
					low_run++;
				else
					in_run = 1'b0;
				if (n == mid && serial_tx !== 1'b0) begin
					error_count++;
					$display("start bit on serial_tx ended before its middle");
				end
				if (n >= flash_dump_pkg::BIT_CYCLES + mid
					&& n <= 8 * flash_dump_pkg::BIT_CYCLES + mid
					&& (n - mid) % flash_dump_pkg::BIT_CYCLES == 0)
					c[(n - mid) / flash_dump_pkg::BIT_CYCLES - 1] = serial_tx;
				if (n == 9 * flash_dump_pkg::BIT_CYCLES + mid)
					stop = serial_tx;
			end
		end
	endtask

	task automatic receive_line();
		for (int i = 0; i < flash_dump_pkg::LINE_CHARS; i++)
			receive_char(line_buf[i], start_len[i], stop_bit[i]);
	endtask

	// reports the first differing character only
	task automatic compare_line(input string name, input logic [23:0] addr);
		int idx;
		idx = 0;
		while (idx < flash_dump_pkg::LINE_CHARS - 1 && line_buf[idx] === expected_char(addr, idx))
			idx++;
		check($sformatf("%s char %0d", name, idx), expected_char(addr, idx), line_buf[idx]);
	endtask

	// ------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------
	task automatic reset_idle();
		int errs;
		logic tx_high;
		logic cs_high;
		errs = error_count;
		tx_high = 1'b1;
		cs_high = 1'b1;
		repeat (16) begin
			@(negedge clk27);
			if (serial_tx !== 1'b1)
				tx_high = 1'b0;
			if (spi.cs_n !== 1'b1)
				cs_high = 1'b0;
		end
		@(posedge clk27);
		rst <= 1'b0;
		repeat (flash_dump_pkg::GAP_CYCLES - 10) begin
			@(negedge clk27);
			if (serial_tx !== 1'b1)
				tx_high = 1'b0;
			if (spi.cs_n !== 1'b1)
				cs_high = 1'b0;
		end
		check("reset_idle serial_tx high", 1, tx_high);
		check("reset_idle cs_n high", 1, cs_high);
		finish_test("reset_idle", errs);
	endtask

	task automatic first_line_layout();
		int errs;
		errs = error_count;
		receive_line();
		compare_line("first_line_layout", 24'h000000);
		check("first_line_layout read opcode", 8'h03, last_cmd);
		for (int i = 0; i < flash_dump_pkg::LINE_CHARS; i++) begin
			first_start_len[i] = start_len[i];
			first_stop[i] = stop_bit[i];
		end
		finish_test("first_line_layout", errs);
	endtask

	task automatic address_increments();
		int errs;
		errs = error_count;
		receive_line();
		compare_line("address_increments line 2", 24'h000001);
		receive_line();
		compare_line("address_increments line 3", 24'h000002);
		check("address_increments flash address", 24'h000002, last_addr);
		finish_test("address_increments", errs);
	endtask

	task automatic hex_and_binary_agree();
		int errs;
		int lines;
		logic [23:0] addr;
		logic [7:0] bin;
		logic [7:0] hex;
		errs = error_count;
		lines = 2 + ($unsigned($random(seed)) % 4);
		addr = 24'h000003;
		for (int i = 0; i < lines; i++) begin
			receive_line();
			check("hex_and_binary_agree address", addr,
				{bin_field(0), bin_field(9), bin_field(18)});
			bin = bin_field(30);
			hex = {hex_value(line_buf[41]), hex_value(line_buf[42])};
			check("hex_and_binary_agree binary vs hex", bin, hex);
			check("hex_and_binary_agree flash byte", model_byte(addr), hex);
			addr = addr + 24'd1;
		end
		finish_test($sformatf("hex_and_binary_agree (%0d lines)", lines), errs);
	endtask

	task automatic frame_timing();
		int errs;
		int want;
		int seen;
		errs = error_count;
		for (int i = 0; i < flash_dump_pkg::LINE_CHARS; i++) begin
			want = low_bits(expected_char(24'h000000, i)) * flash_dump_pkg::BIT_CYCLES;
			// one cycle of tolerance either way
			seen = (first_start_len[i] >= want - 1 && first_start_len[i] <= want + 1) ?
				want : first_start_len[i];
			check($sformatf("frame_timing start bit char %0d", i), want, seen);
			check($sformatf("frame_timing stop bit char %0d", i), 1, first_stop[i]);
		end
		finish_test("frame_timing", errs);
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		seed = 32'h0ee59755;
		rst = 1'b1;
		test_count = 0;
		check_count = 0;
		error_count = 0;

		reset_idle();
		first_line_layout();
		address_increments();
		hex_and_binary_agree();
		frame_timing();

		$display("tests run %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
verilog/flash_dump_pkg.sv
verilog/spi_flash_reader.sv
verilog/uart_tx.sv
verilog/line_formatter.sv
verilog/dump_sequencer.sv
verilog/flash_dump_top.sv
verification/flash_model.sv
verification/tb_flash_dump.sv
